// File: verilog.f
design/pr_pkg.sv
design/pr_ctrl.sv
design/pr_user_reg.sv
design/pr_flags.sv
design/pr_bus_mux.sv
design/pr_top.sv
dv/pr_tb_asserts.sv
dv/pr_tb.sv

// File: dv/pr_tb.sv
// Testbench for pr_top; runs handshaked commands from a table and loops, checks results
`default_nettype none
`timescale 1ns/1ps

module pr_tb;

	import pr_pkg::*;

	typedef struct {
		string       name;
		op_t         op;
		logic [2:0]  addr;
		logic [15:0] data;
		logic [15:0] exp_rd; // Writes see the idle bus
		logic        exp_q;
		logic        exp_bs;
		logic [3:0]  exp_nb;
	} step_t;

	logic        clk;
	logic        reset;
	logic        req;
	reg_cmd_t    cmd;
	logic [15:0] rz;
	logic [15:0] zp;
	logic [9:0]  rs;
	wire         ack;
	wire  [0:15] rdata;
	wire  [0:15] r0;
	wire         q;
	wire         bs;
	wire  [0:3]  nb;
	wire         own_bus;

	step_t       steps[$];
	int          val_errors;
	int          proto_errors;
	logic [31:0] lfsr;
	logic [15:0] user_vals[7];

	pr_top #(.CPU_NUMBER(1)) dut_i (
		.clk(clk), .reset(reset), .req(req), .cmd(cmd),
		.rz(rz), .zp(zp), .rs(rs),
		.ack(ack), .rdata(rdata), .r0(r0), .q(q), .bs(bs), .nb(nb),
		.own_bus(own_bus)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic next_word(output logic [15:0] w);
		for (int b = 0; b < 16; b++) begin
			lfsr = lfsr_step(lfsr);
			w = {w[14:0], lfsr[0]}; // One step per bit
		end
	endtask

	task automatic add_step(input string n, input op_t op, input logic [2:0] a,
			input logic [15:0] d, input logic [15:0] e, input logic eq, input logic ebs,
			input logic [3:0] enb);
		step_t s;
		s = '{n, op, a, d, e, eq, ebs, enb};
		steps.push_back(s);
	endtask

	task automatic check_val(input string n, input logic [15:0] exp, input logic [15:0] act);
		assert (exp === act) else begin
			$display("Fail %s: expected %h, actual %h", n, exp, act);
			val_errors++;
		end
	endtask

	// Four-phase transfer, samples at falling edges
	task automatic run_cmd(input op_t op, input logic [2:0] a, input logic [15:0] d,
			output logic [15:0] rd);
		reg_cmd_t c;
		int       n;
		c.op   = op;
		c.addr = a;
		c.data = d;
		@(posedge clk);
		req <= 1'b1;
		cmd <= c;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!ack && n < 20);
		rd = rdata;
		assert (ack) else begin
			$display("Handshake error: no ack within 20 cycles for op %s", op.name());
			proto_errors++;
		end
		@(posedge clk);
		req <= 1'b0;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (ack && n < 20);
		assert (!ack) else begin
			$display("Handshake error: ack stayed high after req dropped");
			proto_errors++;
		end
	endtask

	initial begin
		add_step("r0_reset",      OP_READ,      3'd0, 16'h0000, 16'h0000, 0, 0, 4'h0);
		add_step("rb_reset",      OP_READ_KI,   3'd2, 16'h0000, 16'h0000, 0, 0, 4'h0);
		add_step("r0_write_sys",  OP_WRITE,     3'd0, 16'ha5c3, 16'hffff, 0, 0, 4'h0);
		add_step("r0_read",       OP_READ,      3'd0, 16'h0000, 16'ha5c3, 0, 0, 4'h0);
		add_step("r0_swap",       OP_READ_SWAP, 3'd0, 16'h0000, 16'hffa5, 0, 0, 4'h0);
		add_step("bar_set",       OP_WRITE_BAR, 3'd0, 16'h003a, 16'hffff, 1, 1, 4'ha);
		add_step("r0_write_user", OP_WRITE,     3'd0, 16'h0f0f, 16'hffff, 1, 1, 4'ha);
		add_step("r0_read_user",  OP_READ,      3'd0, 16'h0000, 16'ha50f, 1, 1, 4'ha);
		add_step("ki_rz",         OP_READ_KI,   3'd0, 16'h0000, 16'h1234, 1, 1, 4'ha);
		add_step("ki_sys",        OP_READ_KI,   3'd1, 16'h0000, 16'ha97a, 1, 1, 4'ha);
		add_step("rb_write",      OP_WRITE_RB,  3'd0, 16'hc0de, 16'hffff, 1, 1, 4'ha);
		add_step("ki_rb",         OP_READ_KI,   3'd2, 16'h0000, 16'hc0de, 1, 1, 4'ha);
		add_step("ki_zp",         OP_READ_KI,   3'd3, 16'h0000, 16'hbeef, 1, 1, 4'ha);
		add_step("clear",         OP_CLEAR,     3'd0, 16'h0000, 16'hffff, 0, 0, 4'h0);
		add_step("r0_cleared",    OP_READ,      3'd0, 16'h0000, 16'h0000, 0, 0, 4'h0);
		add_step("ki_sys_clear",  OP_READ_KI,   3'd1, 16'h0000, 16'ha940, 0, 0, 4'h0);
		add_step("rb_survives",   OP_READ_KI,   3'd2, 16'h0000, 16'hc0de, 0, 0, 4'h0);
		add_step("flags_z_only",  OP_FLAGS,     3'd0, 16'h8400, 16'hffff, 0, 0, 4'h0);
		add_step("read_z",        OP_READ,      3'd0, 16'h0000, 16'h8000, 0, 0, 4'h0);
		add_step("flags_mc_only", OP_FLAGS,     3'd0, 16'h6200, 16'hffff, 0, 0, 4'h0);
		add_step("read_mc",       OP_READ,      3'd0, 16'h0000, 16'hd000, 0, 0, 4'h0);
		add_step("swap_flags",    OP_READ_SWAP, 3'd0, 16'h0000, 16'hffd0, 0, 0, 4'h0);
	end

	// Watchdog sized from the table
	initial begin
		#1;
		#((steps.size() + 7) * 20 * 40);
		$display("Watchdog expired before the tests finished");
		$display("Test failed");
		$finish;
	end

	initial begin
		logic [15:0] rd;
		logic [15:0] r0_v;
		logic [15:0] w;
		logic [6:0]  exp_f;
		logic        zs;
		logic        sg;
		logic        cy;
		logic        ov;
		logic        ar;
		val_errors   = 0;
		proto_errors = 0;
		lfsr  = 32'h1323;
		reset = 1'b1;
		req   = 1'b0;
		cmd   = '0;
		rz    = 16'h1234;
		zp    = 16'hbeef;
		rs    = 10'h2a5;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_val("reset_rdata", 16'h0000, rdata); // Read register cleared by reset
		for (int i = 1; i <= 7; i++) begin
			run_cmd(OP_READ, 3'(i), 16'h0, rd);
			check_val($sformatf("reset_r%0d", i), 16'h0000, rd);
		end
		for (int i = 1; i <= 7; i++) begin // Random user register data
			next_word(w);
			user_vals[i-1] = w;
			run_cmd(OP_WRITE, 3'(i), w, rd);
			run_cmd(OP_READ, 3'(i), 16'h0, rd);
			check_val($sformatf("lfsr_r%0d", i), w, rd);
		end
		foreach (steps[k]) begin
			run_cmd(steps[k].op, steps[k].addr, steps[k].data, rd);
			check_val(steps[k].name, steps[k].exp_rd, rd);
			check_val({steps[k].name, "_sys"}, {9'd0, steps[k].exp_q, steps[k].exp_bs,
				1'b0, steps[k].exp_nb}, {9'd0, q, bs, 1'b0, nb});
			check_val({steps[k].name, "_own_bus"}, {15'd0, ~steps[k].exp_bs}, {15'd0, own_bus});
		end
		for (int k = 0; k < 16; k++) begin // All masks set, every input combination
			ar = k[3];
			zs = k[2];
			sg = k[1];
			cy = k[0];
			ov = k[0] ^ k[1];
			exp_f = {zs, sg, ov, cy, ar ? sg : cy, zs,
				ar ? (!zs && !sg) : (!zs && !cy)};
			run_cmd(OP_FLAGS, 3'd0, {zs, sg, cy, ov, ar, 4'b1111, 7'd0}, rd);
			r0_v = r0;
			check_val($sformatf("flags_%0d", k), {9'd0, exp_f}, {9'd0, r0_v[15:9]});
		end
		for (int i = 1; i <= 7; i++) begin // Clear must leave R1-R7 alone
			run_cmd(OP_READ, 3'(i), 16'h0, rd);
			check_val($sformatf("keep_r%0d", i), user_vals[i-1], rd);
		end
		$display("Errors: %0d value, %0d handshake, %0d assertion", val_errors,
			proto_errors, dut_i.asserts_i.fail_count);
		if (val_errors == 0 && proto_errors == 0 && dut_i.asserts_i.fail_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/pr_tb_asserts.sv
// Handshake assertions for the register unit top level, attached to pr_top by bind
`default_nettype none
`timescale 1ns/1ps

module pr_tb_asserts (
	input wire                   clk,
	input wire                   reset,
	input wire                   req,
	input wire                   ack,
	input wire pr_pkg::reg_cmd_t cmd
);

	int fail_count = 0; // Failed assertions so far

	// ack only answers a pending request
	ack_needs_req: assert property (@(posedge clk) disable iff (reset)
		$rose(ack) |-> req)
		else begin
			$error("ack rose with req low");
			fail_count++;
		end

	// Four-phase rule, requester lets go first
	ack_holds_with_req: assert property (@(posedge clk) disable iff (reset)
		$fell(ack) |-> !req)
		else begin
			$error("ack fell while req still high");
			fail_count++;
		end

	ack_low_in_reset: assert property (@(posedge clk)
		reset |=> !ack)
		else begin
			$error("ack high during reset");
			fail_count++;
		end

	// Command must not move before it is acknowledged
	cmd_stable: assert property (@(posedge clk) disable iff (reset)
		($past(req) && !$past(ack) && req) |-> $stable(cmd))
		else begin
			$error("cmd changed while req waited for ack");
			fail_count++;
		end

endmodule

bind pr_top pr_tb_asserts asserts_i (
	.clk(clk), .reset(reset), .req(req), .ack(ack), .cmd(cmd)
);

`default_nettype wire

// File: design/pr_top.sv
// Top level of the P-R register unit; connects control, user registers, flags block and read mux
`default_nettype none
`timescale 1ns/1ps

module pr_top #(
	parameter int CPU_NUMBER = 0
) (
	input  wire              clk,
	input  wire              reset,
	input  wire              req,
	input  wire pr_pkg::reg_cmd_t cmd,
	input  wire  [0:15]      rz,
	input  wire  [0:15]      zp,
	input  wire  [0:9]       rs,
	output wire              ack,
	output wire  [0:15]      rdata,
	output wire  [0:15]      r0,
	output wire              q,
	output wire              bs,
	output wire  [0:3]       nb,
	output wire              own_bus
);

	import pr_pkg::*;

	wire [6:0]       user_we;
	wire [6:0]       user_re;
	wire [0:15]      wdata;
	wire [6:0][0:15] user_rd;  // Gated readouts
	wire             flags_valid;
	wire reg_cmd_t   flags_cmd;
	wire src_t       src;
	wire [1:0]       ki_sel;
	wire [0:15]      rb;
	wire [0:15]      bus_l;    // Combined read bus

	pr_ctrl ctrl_i (
		.clk(clk), .reset(reset),
		.req(req), .cmd(cmd), .ack(ack), .rdata(rdata),
		.user_we(user_we), .user_re(user_re), .wdata(wdata),
		.flags_valid(flags_valid), .flags_cmd(flags_cmd),
		.src(src), .ki_sel(ki_sel), .bus_l(bus_l)
	);

	// R1-R7
	for (genvar i = 0; i < 7; i++) begin : user_reg_g
		pr_user_reg reg_i (
			.clk(clk), .reset(reset),
			.we(user_we[i]), .re(user_re[i]),
			.wdata(wdata), .rdata(user_rd[i])
		);
	end

	pr_flags #(.CPU_NUMBER(CPU_NUMBER)) flags_i (
		.clk(clk), .reset(reset),
		.valid(flags_valid), .cmd(flags_cmd),
		.r0(r0), .rb(rb), .q(q), .bs(bs), .nb(nb), .own_bus(own_bus)
	);

	pr_bus_mux mux_i (
		.src(src), .ki_sel(ki_sel), .user_rd(user_rd),
		.r0(r0), .rb(rb), .q(q), .bs(bs), .nb(nb),
		.rz(rz), .zp(zp), .rs(rs), .bus_l(bus_l)
	);

endmodule

`default_nettype wire

// File: design/pr_bus_mux.sv
// Read bus combiner: wired-AND of user readouts, plain and swapped R0, and the KI bus sources
`default_nettype none
`timescale 1ns/1ps

module pr_bus_mux (
	input  wire pr_pkg::src_t src,
	input  wire  [1:0]       ki_sel,
	input  wire  [6:0][0:15] user_rd, // One word per user register
	input  wire  [0:15]      r0,
	input  wire  [0:15]      rb,
	input  wire              q,
	input  wire              bs,
	input  wire  [0:3]       nb,
	input  wire  [0:15]      rz,
	input  wire  [0:15]      zp,
	input  wire  [0:9]       rs,
	output logic [0:15]      bus_l
);

	import pr_pkg::*;

	logic [0:15] user_and; // Open-collector equivalent
	logic [0:15] ki;

	always_comb begin
		user_and = '1;
		for (int i = 0; i < 7; i++) begin
			user_and = user_and & user_rd[i]; // Idle sources are all ones
		end
	end

	// KI source select
	always_comb begin
		case (ki_sel)
			2'd0:    ki = rz;
			2'd1:    ki = {rs, bs, q, nb}; // System word
			2'd2:    ki = rb;
			default: ki = zp;
		endcase
	end

	always_comb begin
		case (src)
			SRC_USER:    bus_l = user_and;
			SRC_R0:      bus_l = r0;
			SRC_R0_SWAP: bus_l = {8'hff, r0[0:7]}; // Flags into low byte
			SRC_KI:      bus_l = ki;
			default:     bus_l = '1;
		endcase
	end

endmodule

`default_nettype wire

// File: design/pr_flags.sv
// R0 flags and user bits, Q/BS/NB system fields and RB; executes the non-user-register commands
`default_nettype none
`timescale 1ns/1ps

module pr_flags #(
	parameter int CPU_NUMBER = 0 // Board jumper
) (
	input  wire              clk,
	input  wire              reset,
	input  wire              valid,   // Execute strobe from pr_ctrl
	input  wire pr_pkg::reg_cmd_t cmd,
	output logic [0:15]      r0,
	output logic [0:15]      rb,
	output logic             q,       // User mode
	output logic             bs,
	output logic [0:3]       nb,
	output logic             own_bus
);

	import pr_pkg::*;

	flag_upd_t upd;    // ALU result view of data
	logic      flag_l; // New L value
	logic      flag_g; // New G value

	assign upd = flag_upd_t'(cmd.data);

	// Signed compare uses sign, unsigned uses carry
	assign flag_l = upd.aryt ? upd.sign : upd.carry;
	assign flag_g = upd.aryt ? (~upd.zs & ~upd.sign) : (~upd.zs & ~upd.carry);

	always_ff @(posedge clk) begin
		if (reset) begin
			r0 <= '0;
			rb <= '0;
			q  <= 1'b0;
			bs <= 1'b0;
			nb <= '0;
		end else if (valid) begin
			case (cmd.op)
				OP_WRITE: begin
					r0[FLAG_X:15] <= cmd.data[FLAG_X:15]; // X and user bits always
					if (!q) begin
						r0[FLAG_Z:FLAG_Y] <= cmd.data[FLAG_Z:FLAG_Y]; // Low flags in system mode only
					end
				end
				OP_FLAGS: begin
					if (upd.ust_z) begin
						r0[FLAG_Z] <= upd.zs;
					end
					if (upd.ust_mc) begin
						r0[FLAG_M] <= upd.sign;
						r0[FLAG_C] <= upd.carry;
					end
					if (upd.ust_v) begin
						r0[FLAG_V] <= upd.ovf;
					end
					if (upd.ust_leg) begin
						r0[FLAG_L] <= flag_l;
						r0[FLAG_E] <= upd.zs;
						r0[FLAG_G] <= flag_g;
					end
				end
				OP_WRITE_BAR: begin
					q  <= cmd.data[10];
					bs <= cmd.data[11];
					nb <= cmd.data[12:15];
				end
				OP_WRITE_RB: rb <= cmd.data;
				OP_CLEAR: begin
					r0 <= '0; // RB survives clear
					q  <= 1'b0;
					bs <= 1'b0;
					nb <= '0;
				end
				default: r0 <= r0;
			endcase
		end
	end

	// Bus ownership follows jumper
	assign own_bus = bs ^ CPU_NUMBER[0];

endmodule

`default_nettype wire

// File: design/pr_user_reg.sv
// One 16-bit user register (R1-R7) with write enable and wired-AND style read gating
`default_nettype none
`timescale 1ns/1ps

module pr_user_reg (
	input  wire         clk,
	input  wire         reset,
	input  wire         we,    // Load wdata this edge
	input  wire         re,    // Drive word onto bus
	input  wire  [0:15] wdata,
	output logic [0:15] rdata  // All ones when not selected
);

	logic [0:15] word;

	always_ff @(posedge clk) begin
		if (reset) begin
			word <= '0;
		end else if (we) begin
			word <= wdata;
		end
	end

	// Unselected register pulls nothing low
	assign rdata = re ? word : '1;

endmodule

`default_nettype wire

// File: design/pr_ctrl.sv
// Requester handshake FSM and command decoder; drives register enables and read-source select
`default_nettype none
`timescale 1ns/1ps

module pr_ctrl (
	input  wire              clk,
	input  wire              reset,
	input  wire              req,         // Four-phase request
	input  wire pr_pkg::reg_cmd_t cmd,    // Stable while req high
	output logic             ack,
	output logic [0:15]      rdata,       // Captured at execute
	output logic [6:0]       user_we,     // Bit i writes R(i+1)
	output logic [6:0]       user_re,     // Bit i reads R(i+1)
	output logic [0:15]      wdata,
	output logic             flags_valid, // R0/system side strobe
	output pr_pkg::reg_cmd_t flags_cmd,
	output pr_pkg::src_t     src,
	output logic [1:0]       ki_sel,
	input  wire [0:15]       bus_l        // Combined read bus
);

	import pr_pkg::*;

	typedef enum logic [1:0] {
		IDLE    = 2'd0,
		EXEC    = 2'd1,
		ACK     = 2'd2,
		RELEASE = 2'd3
	} state_t;

	state_t     state;
	state_t     state_nxt;
	logic       exec;     // Execute cycle
	logic       addr_r0;  // Address 0 selects R0
	logic [6:0] addr_hot; // One-hot user register

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (req) begin
					state_nxt = EXEC; // Take command next cycle
				end
			end
			EXEC:    state_nxt = ACK;
			ACK: begin
				if (!req) begin
					state_nxt = RELEASE; // Requester let go
				end
			end
			RELEASE: state_nxt = IDLE; // One dead cycle, req ignored
			default: state_nxt = IDLE;
		endcase
	end

	// ack and read data, both registered
	always_ff @(posedge clk) begin
		if (reset) begin
			ack   <= 1'b0;
			rdata <= '0;
		end else if (exec) begin
			ack   <= 1'b1;
			rdata <= bus_l; // Idle bus reads all ones
		end else if (state == ACK && !req) begin
			ack <= 1'b0;
		end
	end

	assign exec     = (state == EXEC);
	assign addr_r0  = (cmd.addr == 3'd0);
	assign addr_hot = addr_r0 ? 7'd0 : 7'd1 << (cmd.addr - 3'd1);
	assign wdata     = cmd.data;
	assign flags_cmd = cmd;
	assign ki_sel    = cmd.addr[1:0]; // KI source number

	// Command decode, active only in EXEC
	always_comb begin
		user_we     = '0;
		user_re     = '0;
		flags_valid = 1'b0;
		src         = SRC_USER; // No re bits, bus idles high
		if (exec) begin
			case (cmd.op)
				OP_READ: begin
					if (addr_r0) begin
						src = SRC_R0;
					end else begin
						user_re = addr_hot;
					end
				end
				OP_READ_SWAP: src = SRC_R0_SWAP;
				OP_READ_KI:   src = SRC_KI;
				OP_WRITE: begin
					if (addr_r0) begin
						flags_valid = 1'b1; // R0 write goes to flags block
					end else begin
						user_we = addr_hot;
					end
				end
				OP_FLAGS, OP_WRITE_BAR, OP_WRITE_RB, OP_CLEAR: flags_valid = 1'b1;
				default: flags_valid = 1'b0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/pr_pkg.sv
// Shared types and flag positions of the P-R register unit, imported by every design module
`default_nettype none

package pr_pkg;

	// Command opcodes seen on the requester port
	typedef enum logic [2:0] {
		OP_READ      = 3'd0, // R0 or R1-R7 by addr
		OP_READ_SWAP = 3'd1, // R0 flags moved to low byte
		OP_WRITE     = 3'd2, // R0 or R1-R7 by addr
		OP_FLAGS     = 3'd3, // ALU result to flags
		OP_WRITE_BAR = 3'd4, // Q, BS, NB from data
		OP_WRITE_RB  = 3'd5, // Load register
		OP_READ_KI   = 3'd6, // KI bus, addr picks source
		OP_CLEAR     = 3'd7  // R0 and system fields to zero
	} op_t;

	// One requester command, held stable while req is high
	typedef struct packed {
		op_t         op;   // What to do
		logic [2:0]  addr; // Register number or KI select
		logic [0:15] data; // Write data, bit 0 is MSB
	} reg_cmd_t;

	// OP_FLAGS view of the data field
	typedef struct packed {
		logic       zs;      // Result is zero
		logic       sign;    // Result bit 0
		logic       carry;   // Carry out
		logic       ovf;     // Overflow
		logic       aryt;    // Signed compare for L and G
		logic       ust_z;   // Update Z
		logic       ust_mc;  // Update M and C
		logic       ust_v;   // Update V
		logic       ust_leg; // Update L, E and G
		logic [6:0] pad;
	} flag_upd_t;

	// Read bus sources
	typedef enum logic [1:0] {
		SRC_USER    = 2'd0, // AND of user register readouts
		SRC_R0      = 2'd1,
		SRC_R0_SWAP = 2'd2,
		SRC_KI      = 2'd3
	} src_t;

	// Flag bits in R0, MSB-first numbering
	localparam int FLAG_Z = 0;
	localparam int FLAG_M = 1;
	localparam int FLAG_V = 2;
	localparam int FLAG_C = 3;
	localparam int FLAG_L = 4;
	localparam int FLAG_E = 5;
	localparam int FLAG_G = 6;
	localparam int FLAG_Y = 7;
	localparam int FLAG_X = 8;

endpackage

`default_nettype wire
